// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// opcodes live in instr[15:12]; 3 and 7 are unused and act as nop
	typedef enum logic [3:0] {
		opAdd = 4'd0,  // saturating add
		opSub = 4'd1,  // saturating subtract
		opXor = 4'd2,
		opSll = 4'd4,
		opSra = 4'd5,
		opRor = 4'd6,
		opLw  = 4'd8,  // rd <= mem[rs + off]
		opSw  = 4'd9,  // mem[rs + off] <= rd
		opLlb = 4'd10, // low byte of rd <= imm8
		opLhb = 4'd11, // high byte of rd <= imm8
		opB   = 4'd12, // pc relative branch
		opBr  = 4'd13, // branch to rs
		opPcs = 4'd14, // rd <= pc + 2
		opHlt = 4'd15
	} opcodeT;

	typedef enum logic [2:0] {
		condNe = 3'd0,
		condEq = 3'd1,
		condGt = 3'd2,
		condLt = 3'd3,
		condGe = 3'd4,
		condLe = 3'd5,
		condOv = 3'd6,
		condUn = 3'd7  // always taken
	} condT;

	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluXor  = 3'd2,
		aluSll  = 3'd3,
		aluSra  = 3'd4,
		aluRor  = 3'd5,
		aluPass = 3'd6, // result is operand b
		aluAddr = 3'd7  // wrapping add, used for load/store addresses
	} aluOpT;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flagsT;

	typedef struct packed {
		logic [3:0]  srcReg1;
		logic [3:0]  srcReg2;
		logic [3:0]  dstReg;
		logic        regWrite;
		logic        aluSrc;      // 1 selects immediate as alu operand b
		logic        memRead;
		logic        memWrite;
		logic        branch;      // B instruction
		logic        branchReg;   // BR instruction
		logic        jumpAndLink; // PCS
		logic        llb;
		logic        lhb;
		logic        halt;
		aluOpT       aluOp;
		logic        setZ;
		logic        setN;
		logic        setV;
		logic [15:0] immediate;   // already sign extended
	} ctrlT;

	// one retired instruction per cycle
	typedef struct packed {
		logic        regWrite;
		logic [3:0]  regDst;
		logic [15:0] regData;
		logic        memWrite;
		logic [15:0] memAddr;     // word address after wrap
		logic [15:0] memData;
	} traceT;

endpackage

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
	input  logic [15:0]   a,
	input  logic [15:0]   b,
	input  cpuPkg::aluOpT op,
	input  logic [3:0]    shamt,
	output logic [15:0]   result,
	output cpuPkg::flagsT flags
);
	import cpuPkg::*;

	logic        subtract;
	logic        arith;
	logic        overflow;
	logic [15:0] bOperand;
	logic [15:0] rawSum;
	logic [15:0] satSum;
	logic [31:0] rotated;

	assign subtract = (op == aluSub);
	assign arith    = (op == aluAdd) || (op == aluSub);
	assign bOperand = subtract ? ~b : b; // two's complement via carry in
	assign rawSum   = a + bOperand + {15'd0, subtract};

	// same sign in, different sign out
	assign overflow = (a[15] == bOperand[15]) && (rawSum[15] != a[15]);

	// overflow direction always follows the sign of a
	assign satSum = overflow ? (a[15] ? 16'h8000 : 16'h7fff) : rawSum;

	assign rotated = {a, a} >> shamt; // low half is the rotate right

	always_comb begin
		case (op)
			aluAdd:  result = satSum;
			aluSub:  result = satSum;
			aluXor:  result = a ^ b;
			aluSll:  result = a << shamt;
			aluSra:  result = 16'($signed(a) >>> shamt);
			aluRor:  result = rotated[15:0];
			aluAddr: result = rawSum; // no saturation, address wraps
			default: result = b;      // pass
		endcase
	end

	// flags come from the sum before saturation
	assign flags.z = arith ? (rawSum == 16'd0) : (result == 16'd0);
	assign flags.n = rawSum[15];
	assign flags.v = overflow;

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none

module regFile #(
	parameter bit WRITE_THROUGH = 1'b1
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  srcReg1,
	input  logic [3:0]  srcReg2,
	input  logic [3:0]  dstReg,
	input  logic        writeEn,
	input  logic [15:0] writeData,
	output logic [15:0] srcData1,
	output logic [15:0] srcData2
);
	logic [15:0] regs [16];

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (writeEn) begin
			regs[dstReg] <= writeData;
		end
	end

	if (WRITE_THROUGH) begin : gBypass
		// a read of the register being written sees the new value
		assign srcData1 = (writeEn && dstReg == srcReg1) ? writeData : regs[srcReg1];
		assign srcData2 = (writeEn && dstReg == srcReg2) ? writeData : regs[srcReg2];
	end else begin : gDirect
		assign srcData1 = regs[srcReg1]; // old value until the edge
		assign srcData2 = regs[srcReg2];
	end

endmodule

`default_nettype wire

// File: design/controlUnit.sv
`default_nettype none

module controlUnit (
	input  logic [15:0]   instr,
	input  cpuPkg::flagsT flags,
	output cpuPkg::ctrlT  ctrl,
	output logic          branchTaken
);
	import cpuPkg::*;

	opcodeT opcode;
	condT   cond;
	logic   condMet;

	assign opcode = opcodeT'(instr[15:12]);
	assign cond   = condT'(instr[11:9]); // only meaningful for B and BR

	// condition against the stored flags
	always_comb begin
		condMet = 1'b1;
		case (cond)
			condNe: condMet = ~flags.z;
			condEq: condMet = flags.z;
			condGt: condMet = ~flags.z & ~flags.n;
			condLt: condMet = flags.n;
			condGe: condMet = flags.z | ~flags.n;
			condLe: condMet = flags.z | flags.n;
			condOv: condMet = flags.v;
			condUn: condMet = 1'b1;
		endcase
	end

	always_comb begin
		ctrl           = '0;
		ctrl.srcReg1   = instr[7:4];                   // rs
		ctrl.srcReg2   = instr[3:0];                   // rt
		ctrl.dstReg    = instr[11:8];                  // rd
		ctrl.aluOp     = aluPass;
		ctrl.immediate = {{12{instr[3]}}, instr[3:0]}; // 4 bit offset or shamt
		case (opcode)
			opAdd: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAdd;
				ctrl.setZ     = 1'b1;
				ctrl.setN     = 1'b1;
				ctrl.setV     = 1'b1;
			end
			opSub: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluSub;
				ctrl.setZ     = 1'b1;
				ctrl.setN     = 1'b1;
				ctrl.setV     = 1'b1;
			end
			opXor: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluXor;
				ctrl.setZ     = 1'b1; // logic ops touch z only
			end
			opSll: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluSll;
				ctrl.setZ     = 1'b1;
			end
			opSra: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluSra;
				ctrl.setZ     = 1'b1;
			end
			opRor: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluRor;
				ctrl.setZ     = 1'b1;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAddr;
			end
			opSw: begin
				ctrl.srcReg2  = instr[11:8]; // store data comes from rd
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAddr;
			end
			opLlb, opLhb: begin
				ctrl.srcReg2   = instr[11:8]; // old rd value for the merge
				ctrl.regWrite  = 1'b1;
				ctrl.llb       = (opcode == opLlb);
				ctrl.lhb       = (opcode == opLhb);
				ctrl.immediate = {{8{instr[7]}}, instr[7:0]};
			end
			opB: begin
				ctrl.branch    = 1'b1;
				ctrl.immediate = {{6{instr[8]}}, instr[8:0], 1'b0}; // offset in words
			end
			opBr:    ctrl.branchReg = 1'b1; // target is rs
			opPcs: begin
				ctrl.regWrite    = 1'b1;
				ctrl.jumpAndLink = 1'b1;
			end
			opHlt:   ctrl.halt = 1'b1;
			default: ctrl.halt = 1'b0; // codes 3 and 7 do nothing
		endcase
	end

	assign branchTaken = (ctrl.branch | ctrl.branchReg) & condMet;

endmodule

`default_nettype wire

// File: design/dataMem.sv
`default_nettype none

module dataMem #(
	parameter int DATA_DEPTH = 256
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [15:0] writeData,
	input  logic        writeEn,
	output logic [15:0] readData
);
	localparam int ADDR_W = $clog2(DATA_DEPTH);

	logic [15:0]       mem [DATA_DEPTH];
	logic [ADDR_W-1:0] wordAddr;

	assign wordAddr = addr[ADDR_W-1:0]; // wraps modulo depth

	always_ff @(posedge clk) begin
		if (reset) begin
			mem <= '{default: '0};
		end else if (writeEn) begin
			mem[wordAddr] <= writeData;
		end
	end

	assign readData = mem[wordAddr]; // same cycle read

endmodule

`default_nettype wire

// File: design/cpu.sv
`default_nettype none

module cpu #(
	parameter int DATA_DEPTH = 256
) (
	input  logic          clk,
	input  logic          reset,
	input  logic [15:0]   instr,
	output logic [15:0]   pc,
	output logic          halt,
	output cpuPkg::traceT trace
);
	import cpuPkg::*;

	ctrlT        ctrl;
	flagsT       flagsQ;   // stored flags for branches
	flagsT       aluFlags;
	logic        branchTaken;
	logic        regWriteEn;
	logic        memWriteEn;
	logic [15:0] srcData1, srcData2;
	logic [15:0] aluB, aluResult, memData, writeData;
	logic [15:0] pcPlus2, branchTarget, nextPc;

	controlUnit controlUnit_i (
		.instr(instr),
		.flags(flagsQ),
		.ctrl(ctrl),
		.branchTaken(branchTaken)
	);

	// single cycle, so reads see the value from before this instruction
	regFile #(.WRITE_THROUGH(1'b0)) regFile_i (
		.clk(clk),
		.reset(reset),
		.srcReg1(ctrl.srcReg1),
		.srcReg2(ctrl.srcReg2),
		.dstReg(ctrl.dstReg),
		.writeEn(regWriteEn),
		.writeData(writeData),
		.srcData1(srcData1),
		.srcData2(srcData2)
	);

	assign aluB = ctrl.aluSrc ? ctrl.immediate : srcData2;

	alu alu_i (
		.a(srcData1),
		.b(aluB),
		.op(ctrl.aluOp),
		.shamt(ctrl.immediate[3:0]), // rt field
		.result(aluResult),
		.flags(aluFlags)
	);

	dataMem #(.DATA_DEPTH(DATA_DEPTH)) dataMem_i (
		.clk(clk),
		.reset(reset),
		.addr(aluResult),
		.writeData(srcData2),
		.writeEn(memWriteEn),
		.readData(memData)
	);

	// nothing retires during reset or on a halt
	assign regWriteEn = ctrl.regWrite & ~reset & ~ctrl.halt;
	assign memWriteEn = ctrl.memWrite & ~reset & ~ctrl.halt;
	assign halt       = ctrl.halt & ~reset;

	// byte merges first, then load data, link address, alu
	assign writeData = ctrl.lhb         ? {ctrl.immediate[7:0], srcData2[7:0]} :
	                   ctrl.llb         ? {srcData2[15:8], ctrl.immediate[7:0]} :
	                   ctrl.memRead     ? memData :
	                   ctrl.jumpAndLink ? pcPlus2 :
	                   aluResult;

	assign pcPlus2      = pc + 16'd2;
	assign branchTarget = pcPlus2 + ctrl.immediate; // immediate already doubled
	assign nextPc       = ctrl.halt   ? pc :
	                      branchTaken ? (ctrl.branchReg ? srcData1 : branchTarget) :
	                      pcPlus2;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= '0;
			flagsQ <= '0;
		end else begin
			pc <= nextPc;
			if (ctrl.setZ) flagsQ.z <= aluFlags.z; // per flag enables
			if (ctrl.setN) flagsQ.n <= aluFlags.n;
			if (ctrl.setV) flagsQ.v <= aluFlags.v;
		end
	end

	// fields of a write that does not happen read zero
	always_comb begin
		trace          = '0;
		trace.regWrite = regWriteEn;
		trace.memWrite = memWriteEn;
		if (regWriteEn) begin
			trace.regDst  = ctrl.dstReg;
			trace.regData = writeData;
		end
		if (memWriteEn) begin
			trace.memAddr = aluResult & 16'(DATA_DEPTH - 1); // wrapped word address
			trace.memData = srcData2;
		end
	end

endmodule

`default_nettype wire

// File: test/cpu_chk.sv
`default_nettype none

module cpuChk (
	input logic          clk,
	input logic          reset,
	input logic [15:0]   pc,
	input logic          halt,
	input cpuPkg::traceT trace
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned failCount = 0; // assertion failures so far

	// halted core keeps fetching the same word
	pcHeld: assert property (@(posedge clk) disable iff (reset) halt |=> pc == $past(pc))
		else begin
			failCount++;
			$error("pc moved while halt was high");
		end

	quietInReset: assert property (@(posedge clk) reset |-> !trace.regWrite && !trace.memWrite)
		else begin
			failCount++;
			$error("trace shows a write during reset");
		end

	pcEven: assert property (@(posedge clk) disable iff (reset) !pc[0])
		else begin
			failCount++;
			$error("pc is odd");
		end

endmodule

bind cpu cpuChk cpuChk_i (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.halt(halt),
	.trace(trace)
);

`default_nettype wire

// File: test/cpuTb.sv
`default_nettype none

module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DEPTH        = 256;
	localparam int ADDR_W       = $clog2(DEPTH);
	localparam int RESET_CYCLES = 3;
	localparam int N_ALU        = 300;
	localparam int N_BYTE       = 100;
	localparam int N_MEM        = 150;  // store and load pairs
	localparam int N_BRANCH     = 200;  // steps of one to three instructions
	localparam int N_HALT       = 8;
	localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + 32 + N_ALU + N_BYTE + 2 * N_MEM
		+ 3 * N_BRANCH + 16 + N_HALT + 50;

	logic        clk   = 1'b0;
	logic        reset = 1'b1;
	logic [15:0] instr = '0;
	logic [15:0] pc;
	logic        halt;
	traceT       trace;

	// architectural model
	logic [15:0] mRegs [16];
	logic [15:0] mMem [DEPTH];
	logic [15:0] mPc;
	flagsT       mFlags;

	logic [31:0] lcgState     = 32'h2f13fdb6;
	int          checks       = 0;
	int          errors       = 0;
	int          testsRun     = 0;
	int          testsFailed  = 0;
	int          failsAtStart = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	cpu #(.DATA_DEPTH(DEPTH)) dut_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.halt(halt),
		.trace(trace)
	);

	function automatic int failures();
		return errors + int'(dut_i.cpuChk_i.failCount); // bound assertions count too
	endfunction

	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16]; // upper bits have the longer period
	endfunction

	function automatic logic [15:0] randomAluInstr();
		logic [15:0] r;
		opcodeT      op;
		r = nextRand();
		case (r[2:0])
			3'd0, 3'd6: op = opAdd; // add and sub twice as often
			3'd1, 3'd7: op = opSub;
			3'd2:       op = opXor;
			3'd3:       op = opSll;
			3'd4:       op = opSra;
			default:    op = opRor;
		endcase
		r = nextRand();
		return {op, r[11:0]};
	endfunction

	function automatic logic condHolds(input condT c, input flagsT f);
		case (c)
			condNe: return !f.z;
			condEq: return f.z;
			condGt: return !f.z && !f.n;
			condLt: return f.n;
			condGe: return f.z || !f.n;
			condLe: return f.z || f.n;
			condOv: return f.v;
			default: return 1'b1; // unconditional
		endcase
	endfunction

	task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s: expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic checkFlags(input string name, input flagsT exp, input flagsT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s: expected znv %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic checkTrace(input string name, input traceT exp, input traceT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic clearModel();
		foreach (mRegs[i]) begin
			mRegs[i] = '0;
		end
		foreach (mMem[i]) begin
			mMem[i] = '0;
		end
		mPc    = '0;
		mFlags = '0;
	endtask

	// expected outputs of one instruction, then the state after its edge
	task automatic predict(input logic [15:0] ins, output traceT expTrace, output logic expHalt);
		opcodeT      op;
		logic [3:0]  rd, rs, rt;
		logic [15:0] a, b, offset, addr, res, nextPc;
		logic        wr;
		int          sa, sb, sum;
		op       = opcodeT'(ins[15:12]);
		rd       = ins[11:8];
		rs       = ins[7:4];
		rt       = ins[3:0];
		a        = mRegs[rs];
		b        = mRegs[rt];
		offset   = 16'($signed(rt));
		addr     = 16'((a + offset) % DEPTH); // word address wraps
		res      = '0;
		wr       = 1'b0;
		nextPc   = mPc + 16'd2;
		expTrace = '0;
		expHalt  = 1'b0;
		case (op)
			opAdd, opSub: begin
				sa  = int'($signed(a));
				sb  = int'($signed(b));
				sum = (op == opAdd) ? sa + sb : sa - sb; // exact, no wrap
				res = (sum > 32767) ? 16'h7fff : (sum < -32768) ? 16'h8000 : sum[15:0];
				mFlags.z = (sum[15:0] == 16'd0); // flags from the wrapped sum
				mFlags.n = sum[15];
				mFlags.v = (sum > 32767) || (sum < -32768);
				wr = 1'b1;
			end
			opXor: res = a ^ b;
			opSll: res = a << rt;
			opSra: res = (a >> rt) | (a[15] ? ~(16'hffff >> rt) : 16'h0000); // sign fill
			opRor: res = (a >> rt) | (a << (5'd16 - {1'b0, rt}));
			opLw: begin
				res = mMem[addr[ADDR_W-1:0]];
				wr  = 1'b1;
			end
			opSw: begin
				mMem[addr[ADDR_W-1:0]] = mRegs[rd]; // rd holds the store data
				expTrace.memWrite = 1'b1;
				expTrace.memAddr  = addr;
				expTrace.memData  = mRegs[rd];
			end
			opLlb: begin
				res = {mRegs[rd][15:8], ins[7:0]};
				wr  = 1'b1;
			end
			opLhb: begin
				res = {ins[7:0], mRegs[rd][7:0]};
				wr  = 1'b1;
			end
			opB: begin
				if (condHolds(condT'(ins[11:9]), mFlags)) begin
					nextPc = mPc + 16'd2 + 16'(2 * $signed(ins[8:0])); // word offset
				end
			end
			opBr: begin
				if (condHolds(condT'(ins[11:9]), mFlags)) begin
					nextPc = a;
				end
			end
			opPcs: begin
				res = mPc + 16'd2; // return address
				wr  = 1'b1;
			end
			opHlt: begin
				expHalt = 1'b1;
				nextPc  = mPc; // stay on the halt
			end
			default: ; // codes 3 and 7
		endcase
		if (op inside {opXor, opSll, opSra, opRor}) begin
			mFlags.z = (res == 16'd0); // logic ops touch z only
			wr = 1'b1;
		end
		if (wr) begin
			mRegs[rd] = res;
			expTrace.regWrite = 1'b1;
			expTrace.regDst   = rd;
			expTrace.regData  = res;
		end
		mPc = nextPc;
	endtask

	// called on a rising edge, returns on the edge where the instruction retires
	task automatic runInstr(input logic [15:0] ins);
		traceT expTrace;
		logic  expHalt;
		instr <= ins; // fetched word for the model pc
		@(negedge clk);
		checkWord("pc", mPc, pc);
		checkFlags("flags", mFlags, dut_i.flagsQ);
		predict(ins, expTrace, expHalt);
		checkBit("halt", expHalt, halt);
		checkTrace("trace", expTrace, trace);
		@(posedge clk);
	endtask

	task automatic resetDut();
		reset <= 1'b1;
		instr <= '0;
		@(posedge clk);
		repeat (RESET_CYCLES - 1) begin
			@(negedge clk);
			checkWord("pc", 16'h0000, pc);
			checkBit("halt", 1'b0, halt);
			checkTrace("trace", '0, trace); // no writes while in reset
			@(posedge clk);
		end
		reset <= 1'b0; // released on the third edge
		clearModel();
	endtask

	task automatic beginTest();
		failsAtStart = failures();
		testsRun++;
	endtask

	task automatic endTest(input string name);
		int fails;
		fails = failures() - failsAtStart;
		if (fails == 0) begin
			$display("test %0d %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d failures", testsRun, name, fails);
		end
	endtask

	initial begin
		logic [15:0] r;
		logic [15:0] f;
		resetDut();

		beginTest();
		for (int k = 0; k < 16; k++) begin
			r = nextRand();
			runInstr({opLlb, 4'(k), r[7:0]}); // wide start values so sums saturate
			runInstr({opLhb, 4'(k), r[15:8]});
		end
		repeat (N_ALU) begin
			runInstr(randomAluInstr());
		end
		endTest("random alu ops");

		beginTest();
		repeat (N_BYTE) begin
			r = nextRand();
			runInstr({(r[12] ? opLhb : opLlb), r[11:0]});
		end
		endTest("byte loads");

		beginTest();
		repeat (N_MEM) begin
			r = nextRand();
			runInstr({opSw, r[11:0]});
			runInstr({opLw, r[15:12], r[7:0]}); // same rs and offset, other rd
		end
		endTest("store and load");

		beginTest();
		repeat (N_BRANCH) begin
			r = nextRand();
			f = nextRand();
			case (r[1:0])
				2'd0, 2'd1: runInstr(randomAluInstr()); // leaves flags for branches
				2'd2: runInstr({opB, f[11:0]});
				default: begin
					runInstr({opPcs, f[3:0], 8'h00});
					runInstr({opLhb, f[3:0], f[11:4]}); // low byte stays even
					runInstr({opBr, f[15:13], 1'b0, f[3:0], 4'h0});
				end
			endcase
		end
		endTest("branches and links");

		beginTest();
		resetDut();
		for (int k = 0; k < 16; k++) begin
			runInstr({opSll, 4'(k), 4'(k), 4'h0}); // zero shift copies rk to the trace
		end
		repeat (N_HALT) begin
			runInstr({opHlt, 12'h000});
		end
		endTest("reset and halt");

		$display("%0d tests run, %0d failed, %0d checks, %0d failures",
			testsRun, testsFailed, checks, failures());
		if (failures() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog: no result after %0d cycles, run stopped", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/controlUnit.sv
design/dataMem.sv
design/cpu.sv
test/cpu_chk.sv
test/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
